// ==== hw/rv_mem_pkg.sv ====
package rv_mem_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    // word lane select inside a line
    localparam int LANE_LSB = 2;
    localparam int LANE_W   = $clog2(WORDS_PER_LINE);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    // address with the lane bits cleared
    function automatic addr_t line_base(input addr_t addr);
        addr_t base;
        base = addr;
        base[LANE_LSB +: LANE_W] = '0;
        return base;
    endfunction

    function automatic logic [LANE_W-1:0] lane_of(input addr_t addr);
        return addr[LANE_LSB +: LANE_W];
    endfunction

endpackage

// ==== hw/rv_bus_pkg.sv ====
package rv_bus_pkg;

    localparam int REQ_ID_W = 3;
    localparam int STATE_W  = 2;

    // declaration order is the arbitration priority, highest first
    // after REQ_NONE
    typedef enum logic [REQ_ID_W-1:0] {
        REQ_NONE   = 3'd0,
        REQ_DWB    = 3'd1,
        REQ_DRD    = 3'd2,
        REQ_UNC    = 3'd3,
        REQ_ICACHE = 3'd4
    } req_id_t;

    // idle, transfer on the bus, completion cycle with ready pulse
    typedef enum logic [STATE_W-1:0] {
        S_IDLE = 2'd0,
        S_BUS  = 2'd1,
        S_DONE = 2'd2
    } seq_state_t;

    function automatic logic is_dcache(input req_id_t id);
        return (id == REQ_DWB) || (id == REQ_DRD);
    endfunction

endpackage

// ==== hw/bus_req_if.sv ====
interface bus_req_if import rv_mem_pkg::*, rv_bus_pkg::*; ();

    logic    grant;
    req_id_t id;
    logic    rw;
    addr_t   addr;
    line_t   data;
    // high from the cycle after grant through the ready cycle
    logic    busy;

    modport arb (
        output grant,
        output id,
        output rw,
        output addr,
        output data,
        input  busy
    );

    modport seq (
        input  grant,
        input  id,
        input  rw,
        input  addr,
        input  data,
        output busy
    );

endinterface

// ==== hw/bus_arbiter.sv ====
module bus_arbiter import rv_mem_pkg::*, rv_bus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      icache_req_i,
    input  addr_t     icache_addr_i,

    input  logic      dcache_rd_req_i,
    input  addr_t     dcache_rd_addr_i,
    input  logic      dcache_wb_req_i,
    input  addr_t     dcache_wb_addr_i,
    input  line_t     dcache_wb_data_i,

    input  logic      unc_req_i,
    input  logic      unc_rw_i,
    input  addr_t     unc_addr_i,
    input  word_t     unc_wdata_i,

    input  logic      core_wait_i,

    bus_req_if.arb    req
);

    req_id_t pick_id;
    logic    pick_rw;
    addr_t   pick_addr;
    line_t   pick_data;
    logic    can_grant;
    logic    take;

    // no decision in the grant cycle itself as busy is not up yet
    assign can_grant = !req.busy && !req.grant && !core_wait_i;
    assign take      = can_grant && (pick_id != REQ_NONE);

    always_comb begin
        pick_id   = REQ_NONE;
        pick_rw   = 1'b0;
        pick_addr = '0;
        pick_data = '0;
        if (dcache_wb_req_i) begin
            pick_id   = REQ_DWB;
            pick_rw   = 1'b1;
            pick_addr = line_base(dcache_wb_addr_i);
            pick_data = dcache_wb_data_i;
        end else if (dcache_rd_req_i) begin
            pick_id   = REQ_DRD;
            pick_addr = line_base(dcache_rd_addr_i);
        end else if (unc_req_i) begin
            pick_id   = REQ_UNC;
            pick_rw   = unc_rw_i;
            pick_addr = unc_addr_i;
            // single word goes out in its own lane
            if (unc_rw_i) begin
                pick_data[lane_of(unc_addr_i)*WORD_W +: WORD_W] = unc_wdata_i;
            end
        end else if (icache_req_i) begin
            pick_id   = REQ_ICACHE;
            pick_addr = line_base(icache_addr_i);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req.grant <= 1'b0;
            req.id    <= REQ_NONE;
        end else begin
            req.grant <= take;
            if (take) begin
                req.id <= pick_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req.rw   <= pick_rw;
            req.addr <= pick_addr;
            req.data <= pick_data;
        end
    end

    // the sequencer must be idle whenever a new grant shows up
    a_grant_not_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(req.grant) |-> !req.busy);

endmodule

// ==== hw/bus_sequencer.sv ====
module bus_sequencer import rv_mem_pkg::*, rv_bus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,

    bus_req_if.seq    req,

    input  logic      icache_cancel_i,

    input  logic      axi_rd_over_i,
    input  logic      axi_wr_over_i,

    output logic      bus_valid_req_o,
    output logic      bus_rw_o,
    output addr_t     bus_addr_o,
    output line_t     bus_data_o,

    output logic      icache_ready_o,
    output logic      dcache_ready_o,
    output logic      unc_ready_o,

    output logic      cap_o,
    output logic      busy_o
);

    seq_state_t state_q;
    seq_state_t state_d;
    req_id_t    id_q;
    logic       valid_q;
    logic       cancel_q;
    logic       rw_q;
    addr_t      addr_q;
    line_t      data_q;
    logic       icache_ready_q;
    logic       dcache_ready_q;
    logic       unc_ready_q;
    logic       start;
    logic       over_hit;
    logic       cancelled;

    assign start     = (state_q == S_IDLE) && req.grant;
    // a read ends on rd_over, a write on wr_over
    assign over_hit  = (state_q == S_BUS) && (rw_q ? axi_wr_over_i : axi_rd_over_i);
    assign cancelled = cancel_q || icache_cancel_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: if (req.grant) state_d = S_BUS;
            S_BUS:  if (over_hit) state_d = S_DONE;
            S_DONE: state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= S_IDLE;
            id_q           <= REQ_NONE;
            valid_q        <= 1'b0;
            cancel_q       <= 1'b0;
            icache_ready_q <= 1'b0;
            dcache_ready_q <= 1'b0;
            unc_ready_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                id_q     <= req.id;
                valid_q  <= 1'b1;
                cancel_q <= icache_cancel_i;
            end else if (state_q == S_BUS) begin
                cancel_q <= cancelled;
                if (over_hit) begin
                    valid_q <= 1'b0;
                end
            end
            // jump during refill drops the icache delivery only
            icache_ready_q <= over_hit && (id_q == REQ_ICACHE) && !cancelled;
            dcache_ready_q <= over_hit && is_dcache(id_q);
            unc_ready_q    <= over_hit && (id_q == REQ_UNC);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rw_q   <= req.rw;
            addr_q <= req.addr;
            data_q <= req.data;
        end
    end

    assign busy_o          = (state_q != S_IDLE);
    assign req.busy        = busy_o;
    assign cap_o           = over_hit && !rw_q;

    assign bus_valid_req_o = valid_q;
    assign bus_rw_o        = rw_q;
    assign bus_addr_o      = addr_q;
    assign bus_data_o      = data_q;

    assign icache_ready_o  = icache_ready_q;
    assign dcache_ready_o  = dcache_ready_q;
    assign unc_ready_o     = unc_ready_q;

    // request must not move while the memory side works on it
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus_valid_req_o && $past(bus_valid_req_o) |-> $stable(bus_addr_o) && $stable(bus_rw_o));

    a_one_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({icache_ready_o, dcache_ready_o, unc_ready_o}));

endmodule

// ==== hw/resp_hold.sv ====
module resp_hold import rv_mem_pkg::*; #(
    parameter type payload_t = line_t
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              cap_i,
    input  logic [LANE_W-1:0] lane_i,
    input  line_t             line_i,
    output payload_t          data_o
);

    localparam int PAYLOAD_W = $bits(payload_t);

    payload_t data_q;
    payload_t data_d;

    generate
        if (PAYLOAD_W == LINE_W) begin : g_line
            // whole returned line
            assign data_d = payload_t'(line_i);
        end else begin : g_word
            // one word picked by the lane of the request
            assign data_d = payload_t'(line_i[lane_i*WORD_W +: WORD_W]);
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q <= '0;
        end else if (cap_i) begin
            data_q <= data_d;
        end
    end

    assign data_o = data_q;

endmodule

// ==== hw/rvcore_bus.sv ====
module rvcore_bus import rv_mem_pkg::*; (
    input  logic    clk,
    input  logic    arst_n_i,

    // icache side
    input  logic    icache_req_i,
    input  addr_t   icache_addr_i,
    input  logic    icache_cancel_i,
    output logic    icache_ready_o,
    output line_t   icache_data_o,

    // dcache side
    input  logic    dcache_rd_req_i,
    input  addr_t   dcache_rd_addr_i,
    input  logic    dcache_wb_req_i,
    input  addr_t   dcache_wb_addr_i,
    input  line_t   dcache_wb_data_i,
    output logic    dcache_ready_o,
    output line_t   dcache_data_o,

    // uncached access from execute
    input  logic    unc_req_i,
    input  logic    unc_rw_i,
    input  addr_t   unc_addr_i,
    input  word_t   unc_wdata_i,
    output logic    unc_ready_o,
    output word_t   unc_rdata_o,

    // memory interface
    input  line_t   axi_data_i,
    input  logic    axi_rd_over_i,
    input  logic    axi_wr_over_i,
    input  logic    core_wait_i,
    output logic    core_wait_o,

    output logic    bus_valid_req_o,
    output logic    bus_rw_o,
    output addr_t   bus_addr_o,
    output line_t   bus_data_o
);

    logic  cap;
    logic  busy;
    line_t line_hold;

    bus_req_if u_req ();

    bus_arbiter u_arb (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .icache_req_i     (icache_req_i),
        .icache_addr_i    (icache_addr_i),
        .dcache_rd_req_i  (dcache_rd_req_i),
        .dcache_rd_addr_i (dcache_rd_addr_i),
        .dcache_wb_req_i  (dcache_wb_req_i),
        .dcache_wb_addr_i (dcache_wb_addr_i),
        .dcache_wb_data_i (dcache_wb_data_i),
        .unc_req_i        (unc_req_i),
        .unc_rw_i         (unc_rw_i),
        .unc_addr_i       (unc_addr_i),
        .unc_wdata_i      (unc_wdata_i),
        .core_wait_i      (core_wait_i),
        .req              (u_req)
    );

    bus_sequencer u_seq (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req             (u_req),
        .icache_cancel_i (icache_cancel_i),
        .axi_rd_over_i   (axi_rd_over_i),
        .axi_wr_over_i   (axi_wr_over_i),
        .bus_valid_req_o (bus_valid_req_o),
        .bus_rw_o        (bus_rw_o),
        .bus_addr_o      (bus_addr_o),
        .bus_data_o      (bus_data_o),
        .icache_ready_o  (icache_ready_o),
        .dcache_ready_o  (dcache_ready_o),
        .unc_ready_o     (unc_ready_o),
        .cap_o           (cap),
        .busy_o          (busy)
    );

    // refill lines for both caches
    resp_hold #(.payload_t(line_t)) u_line_hold (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .cap_i    (cap),
        .lane_i   (lane_of(bus_addr_o)),
        .line_i   (axi_data_i),
        .data_o   (line_hold)
    );

    resp_hold #(.payload_t(word_t)) u_unc_hold (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .cap_i    (cap),
        .lane_i   (lane_of(bus_addr_o)),
        .line_i   (axi_data_i),
        .data_o   (unc_rdata_o)
    );

    assign icache_data_o = line_hold;
    assign dcache_data_o = line_hold;

    // stalls the core while a transfer runs or memory holds off
    assign core_wait_o = busy | core_wait_i;

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge away from the sampling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== verif/tb_rvcore_bus.sv ====
module tb_rvcore_bus import rv_mem_pkg::*, rv_bus_pkg::*; ();

    localparam int          NUM_ROWS = 9;
    localparam int          TIMEOUT  = 100;
    localparam logic [31:0] SEED     = 32'h33a0_b92e;
    localparam line_t       WB_LINE  = 128'hdead_beef_0123_4567_89ab_cdef_5a5a_a5a5;

    typedef struct packed {
        // bit 0 icache, bit 1 data refill, bit 2 writeback, bit 3 uncached
        logic [3:0]      mask;
        logic            rw;
        addr_t           addr;
        line_t           wdata;
        // cycle of a one-cycle jump or -1 for none
        int              cancel;
        int              wait_cyc;
        int              n_xfer;
        int              n_exp;
        // entry 0 is the first ready expected
        logic [3:0][2:0] order;
        line_t           exp_data;
    } row_t;

    logic  clk, arst_n_i;
    logic  icache_req_i, icache_cancel_i, icache_ready_o;
    logic  dcache_rd_req_i, dcache_wb_req_i, dcache_ready_o;
    logic  unc_req_i, unc_rw_i, unc_ready_o;
    logic  axi_rd_over_i, axi_wr_over_i, core_wait_i, core_wait_o;
    logic  bus_valid_req_o, bus_rw_o;
    addr_t icache_addr_i, dcache_rd_addr_i, dcache_wb_addr_i, unc_addr_i, bus_addr_o;
    word_t unc_wdata_i, unc_rdata_o;
    line_t icache_data_o, dcache_data_o, dcache_wb_data_i, axi_data_i, bus_data_o;

    row_t        rows [NUM_ROWS];
    logic [2:0]  got_ids [4];
    int          n_got;
    int          checks;
    int          errors;
    logic        timed_out;
    logic [31:0] lcg_state;
    line_t       wr_line;

    tb_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk), .arst_n_o(arst_n_i));

    rvcore_bus u_dut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // lane k of line address A holds A + k
    function automatic line_t mem_line(input addr_t a);
        line_t l;
        addr_t base;
        int    k;
        base = a & ~32'hc;
        for (k = 0; k < WORDS_PER_LINE; k++) begin
            l[k*32 +: 32] = base + k;
        end
        return l;
    endfunction

    // memory model answering each request after 1 to 6 cycles
    initial begin
        int delay;
        axi_data_i    = '0;
        axi_rd_over_i = 1'b0;
        axi_wr_over_i = 1'b0;
        lcg_state     = SEED;
        forever begin
            @(negedge clk);
            if (bus_valid_req_o) begin
                lcg_state = lcg_next(lcg_state);
                delay = 1 + int'(lcg_state[23:16] % 8'd6);
                if (bus_rw_o) wr_line = bus_data_o;
                repeat (delay) @(negedge clk);
                if (bus_rw_o) begin
                    axi_wr_over_i = 1'b1;
                end else begin
                    axi_data_i    = mem_line(bus_addr_o);
                    axi_rd_over_i = 1'b1;
                end
                @(negedge clk);
                axi_rd_over_i = 1'b0;
                axi_wr_over_i = 1'b0;
            end
        end
    end

    task automatic take_ready(input int r, input req_id_t id);
        addr_t exp_addr;
        line_t got_line;
        exp_addr = (id == REQ_UNC) ? rows[r].addr : (rows[r].addr & ~32'hc);
        checks++;
        if (bus_addr_o !== exp_addr) begin
            errors++;
            $display("error at %0t: row %0d bus address %h, expected %h",
                     $time, r, bus_addr_o, exp_addr);
        end
        if (rows[r].n_exp == 1) begin
            case (id)
                REQ_ICACHE: got_line = icache_data_o;
                REQ_DRD:    got_line = dcache_data_o;
                REQ_UNC:    got_line = rows[r].rw ? wr_line : {96'd0, unc_rdata_o};
                default:    got_line = wr_line;
            endcase
            checks++;
            if (got_line !== rows[r].exp_data) begin
                errors++;
                $display("error at %0t: row %0d data %h, expected %h",
                         $time, r, got_line, rows[r].exp_data);
            end
        end
        if (n_got < 4) got_ids[n_got] = id;
        n_got++;
        // requester drops its level on its own ready
        case (id)
            REQ_ICACHE: icache_req_i    = 1'b0;
            REQ_DRD:    dcache_rd_req_i = 1'b0;
            REQ_DWB:    dcache_wb_req_i = 1'b0;
            default:    unc_req_i       = 1'b0;
        endcase
    endtask

    task automatic run_row(input int r);
        int   cyc;
        int   xfer_done;
        int   i;
        logic prev_valid;
        n_got            = 0;
        xfer_done        = 0;
        cyc              = 0;
        prev_valid       = bus_valid_req_o;
        icache_req_i     = rows[r].mask[0];
        dcache_rd_req_i  = rows[r].mask[1];
        dcache_wb_req_i  = rows[r].mask[2];
        unc_req_i        = rows[r].mask[3];
        icache_addr_i    = rows[r].addr;
        dcache_rd_addr_i = rows[r].addr;
        dcache_wb_addr_i = rows[r].addr;
        unc_addr_i       = rows[r].addr;
        unc_rw_i         = rows[r].rw;
        dcache_wb_data_i = rows[r].wdata;
        unc_wdata_i      = rows[r].wdata[31:0];
        core_wait_i      = (rows[r].wait_cyc > 0);
        while (xfer_done < rows[r].n_xfer && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            // core is held for the whole transfer
            checks++;
            if (bus_valid_req_o && !core_wait_o) begin
                errors++;
                $display("error at %0t: row %0d core not held during a transfer", $time, r);
            end
            if (cyc <= rows[r].wait_cyc) begin
                checks++;
                if (bus_valid_req_o || !core_wait_o) begin
                    errors++;
                    $display("error at %0t: row %0d bus started or core not held during wait",
                             $time, r);
                end
                if (cyc == rows[r].wait_cyc) core_wait_i = 1'b0;
            end
            icache_cancel_i = (cyc == rows[r].cancel);
            if (prev_valid && !bus_valid_req_o) xfer_done++;
            prev_valid = bus_valid_req_o;
            if (icache_ready_o) take_ready(r, REQ_ICACHE);
            if (dcache_ready_o) take_ready(r, bus_rw_o ? REQ_DWB : REQ_DRD);
            if (unc_ready_o) take_ready(r, REQ_UNC);
        end
        if (xfer_done < rows[r].n_xfer) begin
            timed_out = 1'b1;
            $display("timeout: row %0d finished %0d of %0d bus transfers",
                     r, xfer_done, rows[r].n_xfer);
        end
        icache_req_i    = 1'b0;
        dcache_rd_req_i = 1'b0;
        dcache_wb_req_i = 1'b0;
        unc_req_i       = 1'b0;
        icache_cancel_i = 1'b0;
        core_wait_i     = 1'b0;
        // bus stays quiet once all requests are gone
        cyc = 0;
        while (cyc < 4) begin
            @(negedge clk);
            cyc++;
            checks++;
            if (bus_valid_req_o || icache_ready_o || dcache_ready_o || unc_ready_o) begin
                errors++;
                $display("error at %0t: row %0d bus activity after the last transfer", $time, r);
            end
        end
        checks++;
        if (n_got != rows[r].n_exp) begin
            errors++;
            $display("error at %0t: row %0d saw %0d ready pulses, expected %0d",
                     $time, r, n_got, rows[r].n_exp);
        end else begin
            for (i = 0; i < n_got; i++) begin
                if (got_ids[i] != rows[r].order[i]) begin
                    errors++;
                    $display("error at %0t: row %0d ready %0d from id %0d, expected id %0d",
                             $time, r, i, got_ids[i], rows[r].order[i]);
                end
            end
        end
    endtask

    initial begin
        int cyc;
        int r;
        checks           = 0;
        errors           = 0;
        timed_out        = 1'b0;
        icache_req_i     = 1'b0;
        icache_addr_i    = '0;
        icache_cancel_i  = 1'b0;
        dcache_rd_req_i  = 1'b0;
        dcache_rd_addr_i = '0;
        dcache_wb_req_i  = 1'b0;
        dcache_wb_addr_i = '0;
        dcache_wb_data_i = '0;
        unc_req_i        = 1'b0;
        unc_rw_i         = 1'b0;
        unc_addr_i       = '0;
        unc_wdata_i      = '0;
        core_wait_i      = 1'b0;

        // mask, rw, addr, wdata, cancel, wait, transfers, readies, order, expected data
        rows[0] = '{4'h1, 1'b0, 32'h0000_1238, '0, -1, 0, 1, 1, {9'd0, REQ_ICACHE},
                    128'h0000_1233_0000_1232_0000_1231_0000_1230};
        rows[1] = '{4'h2, 1'b0, 32'h0000_2a44, '0, -1, 0, 1, 1, {9'd0, REQ_DRD},
                    128'h0000_2a43_0000_2a42_0000_2a41_0000_2a40};
        rows[2] = '{4'h4, 1'b0, 32'h0000_3f0c, WB_LINE, -1, 0, 1, 1, {9'd0, REQ_DWB}, WB_LINE};
        rows[3] = '{4'h8, 1'b0, 32'h0000_4008, '0, -1, 0, 1, 1, {9'd0, REQ_UNC}, 128'h4002};
        rows[4] = '{4'h8, 1'b1, 32'h0000_500c, 128'hcafe_f00d, -1, 0, 1, 1, {9'd0, REQ_UNC},
                    {32'hcafe_f00d, 96'd0}};
        rows[5] = '{4'hf, 1'b0, 32'h0000_6004, WB_LINE, -1, 0, 4, 4,
                    {REQ_ICACHE, REQ_UNC, REQ_DRD, REQ_DWB}, '0};
        rows[6] = '{4'h1, 1'b0, 32'h0000_7010, '0, 1, 0, 1, 0, 12'd0, '0};
        rows[7] = '{4'h1, 1'b0, 32'h0000_7110, '0, 2, 0, 1, 0, 12'd0, '0};
        rows[8] = '{4'h2, 1'b0, 32'h0000_8020, '0, -1, 5, 1, 1, {9'd0, REQ_DRD},
                    128'h0000_8023_0000_8022_0000_8021_0000_8020};

        cyc = 0;
        while (!arst_n_i && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (!arst_n_i) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        @(negedge clk);
        checks++;
        if (bus_valid_req_o || icache_ready_o || dcache_ready_o || unc_ready_o || core_wait_o) begin
            errors++;
            $display("error at %0t: outputs not idle after reset", $time);
        end

        for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(r);
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== rvcore_bus.f ====
hw/rv_mem_pkg.sv
hw/rv_bus_pkg.sv
hw/bus_req_if.sv
hw/bus_arbiter.sv
hw/bus_sequencer.sv
hw/resp_hold.sv
hw/rvcore_bus.sv
verif/tb_clk_gen.sv
verif/tb_rvcore_bus.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bus controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f rvcore_bus.f --top-module tb_rvcore_bus -o sim
./obj_dir/sim | tee sim.log
if grep -q "^Finished with no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
